// ==== hw/div_pkg.sv ====
/* shared types and the default operand width of the integer divider unit
   every divider module and the testbench take these by a wildcard import */
`default_nettype none

package div_pkg;

  // operand width used unless the top level is given another
  localparam int DIV_WIDTH_DEFAULT = 32;

  // ----------------------------------------
  // request function code
  // ----------------------------------------

  // signed treats both operands as two's complement
  typedef enum logic {
    FN_DIV_SIGNED   = 1'b0,
    FN_DIV_UNSIGNED = 1'b1
  } div_fn_t;

  // ----------------------------------------
  // iterative core control
  // ----------------------------------------

  // idle waits for operands, calc runs the loop, done holds the result
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } core_state_t;

endpackage

`default_nettype wire

// ==== hw/div_operand_stage.sv ====
/* first stage of the divider, takes a request and registers operand magnitudes
   plus the sign flags that the sign-fix stage needs at the end */
`default_nettype none

module div_operand_stage
  import div_pkg::*;
#(
  parameter int width = DIV_WIDTH_DEFAULT
) (
  input  logic             clk,
  input  logic             reset,

  // request side
  input  div_fn_t          req_fn,
  input  logic [width-1:0] req_a,
  input  logic [width-1:0] req_b,
  input  logic             req_val,
  output logic             req_rdy,

  // towards the iterative core
  output logic             op_val,
  output logic [width-1:0] op_mag_a,
  output logic [width-1:0] op_mag_b,
  output logic             op_neg_quot,
  output logic             op_neg_rem,
  input  logic             op_rdy
);

  logic             is_signed;
  logic             neg_a;
  logic             neg_b;
  logic [width-1:0] mag_a;
  logic [width-1:0] mag_b;
  logic             take;

  // ----------------------------------------
  // sign detection and magnitudes
  // ----------------------------------------

  // unsigned requests never look at the top bit
  assign is_signed = (req_fn == FN_DIV_SIGNED);
  assign neg_a     = is_signed && req_a[width-1];
  assign neg_b     = is_signed && req_b[width-1];

  // two's complement magnitude, most negative value maps onto itself
  assign mag_a = neg_a ? -req_a : req_a;
  assign mag_b = neg_b ? -req_b : req_b;

  // ----------------------------------------
  // one-entry holding register
  // ----------------------------------------

  // room when empty or when the core drains us this cycle
  assign req_rdy = !op_val || op_rdy;
  assign take    = req_val && req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      op_val <= 1'b0;
    end else if (take) begin
      op_val <= 1'b1;
    end else if (op_rdy) begin
      op_val <= 1'b0;
    end
  end

  // payload only moves on a request handshake
  always_ff @(posedge clk) begin
    if (take) begin
      op_mag_a    <= mag_a;
      op_mag_b    <= mag_b;
      // quotient negative when exactly one operand is
      op_neg_quot <= neg_a ^ neg_b;
      // remainder follows the dividend
      op_neg_rem  <= neg_a;
    end
  end

endmodule

`default_nettype wire

// ==== hw/div_iterative_core.sv ====
/* restoring shift-subtract divider on operand magnitudes, one quotient bit
   per cycle, holds its result until the sign-fix stage takes it */
`default_nettype none

module div_iterative_core
  import div_pkg::*;
#(
  parameter int width = DIV_WIDTH_DEFAULT
) (
  input  logic             clk,
  input  logic             reset,

  // from the operand stage
  input  logic             op_val,
  input  logic [width-1:0] op_mag_a,
  input  logic [width-1:0] op_mag_b,
  input  logic             op_neg_quot,
  input  logic             op_neg_rem,
  output logic             op_rdy,

  // towards the sign-fix stage
  output logic             core_val,
  output logic [width-1:0] core_quot,
  output logic [width-1:0] core_rem,
  output logic             core_neg_quot,
  output logic             core_neg_rem,
  input  logic             core_rdy
);

  // counter must be able to hold width itself
  localparam int cnt_w = $clog2(width + 1);

  core_state_t        state;
  logic [cnt_w-1:0]   cnt;
  logic               accept;
  logic               last_step;

  // remainder in the upper half, dividend bits and quotient in the lower half
  logic [2*width-1:0] rem_q;
  // divisor sits in the upper half, lower half stays zero
  logic [2*width-1:0] div_q;
  logic [2*width:0]   shifted;
  logic [2*width:0]   diff;

  // ----------------------------------------
  // handshake and status
  // ----------------------------------------

  assign op_rdy    = (state == ST_IDLE);
  assign accept    = op_val && op_rdy;
  assign core_val  = (state == ST_DONE);
  assign last_step = (cnt == cnt_w'(width - 1));

  // ----------------------------------------
  // control FSM
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_CALC;
            cnt   <= '0;
          end
        end
        ST_CALC: begin
          // one step per cycle, width steps in all
          cnt <= cnt + 1'b1;
          if (last_step) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          // wait for the sign-fix stage to take the result
          if (core_rdy) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  // extra top bit catches a negative trial difference
  assign shifted = {rem_q, 1'b0};
  assign diff    = shifted - {1'b0, div_q};

  always_ff @(posedge clk) begin
    if (accept) begin
      rem_q         <= {{width{1'b0}}, op_mag_a};
      div_q         <= {op_mag_b, {width{1'b0}}};
      core_neg_quot <= op_neg_quot;
      core_neg_rem  <= op_neg_rem;
    end else if (state == ST_CALC) begin
      // restore on borrow, otherwise keep difference and shift in a one
      if (diff[2*width]) begin
        rem_q <= shifted[2*width-1:0];
      end else begin
        rem_q <= {diff[2*width-1:1], 1'b1};
      end
    end
  end

  // zero divisor never borrows, giving all ones over the dividend
  assign core_quot = rem_q[width-1:0];
  assign core_rem  = rem_q[2*width-1:width];

  // ----------------------------------------
  // assertions
  // ----------------------------------------

  // nothing new is loaded while an item is in progress
  a_accept_idle: assert property (@(posedge clk) disable iff (reset)
    state != ST_IDLE |=> $stable(div_q) && $stable(core_neg_quot)
      && $stable(core_neg_rem))
    else $error("core accepted an item outside idle");

  // held result must not move while the next stage stalls
  a_hold_result: assert property (@(posedge clk) disable iff (reset)
    core_val && !core_rdy |=> core_val && $stable(core_quot) && $stable(core_rem)
      && $stable(core_neg_quot) && $stable(core_neg_rem))
    else $error("core result changed while stalled");

  a_cnt_range: assert property (@(posedge clk) disable iff (reset)
    cnt <= cnt_w'(width))
    else $error("step counter ran past width");

endmodule

`default_nettype wire

// ==== hw/div_sign_fix_stage.sv ====
/* last stage of the divider, negates quotient and remainder where the sign
   flags say so and holds the packed result until the consumer takes it */
`default_nettype none

module div_sign_fix_stage
  import div_pkg::*;
#(
  parameter int width = DIV_WIDTH_DEFAULT
) (
  input  logic               clk,
  input  logic               reset,

  // from the iterative core
  input  logic               core_val,
  input  logic [width-1:0]   core_quot,
  input  logic [width-1:0]   core_rem,
  input  logic               core_neg_quot,
  input  logic               core_neg_rem,
  output logic               core_rdy,

  // response side
  output logic [2*width-1:0] resp_result,
  output logic               resp_val,
  input  logic               resp_rdy
);

  logic             take;
  logic [width-1:0] quot_fix;
  logic [width-1:0] rem_fix;

  // ----------------------------------------
  // sign restore
  // ----------------------------------------

  // min value over minus one wraps back to min value here
  assign quot_fix = core_neg_quot ? -core_quot : core_quot;
  assign rem_fix  = core_neg_rem ? -core_rem : core_rem;

  // ----------------------------------------
  // output register
  // ----------------------------------------

  // free when empty or when the consumer takes the current result
  assign core_rdy = !resp_val || resp_rdy;
  assign take     = core_val && core_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (take) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // remainder in the upper half, quotient in the lower half
  always_ff @(posedge clk) begin
    if (take) begin
      resp_result <= {rem_fix, quot_fix};
    end
  end

  // a response once offered stays until it is taken, payload unchanged
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else $error("response dropped or changed before resp_rdy");

endmodule

`default_nettype wire

// ==== hw/int_div_unit.sv ====
/* iterative integer divider unit, operand stage into iterative core into
   sign-fix stage, valid/ready on every link and up to three items in flight */
`default_nettype none

module int_div_unit
  import div_pkg::*;
#(
  parameter int width = DIV_WIDTH_DEFAULT
) (
  input  logic               clk,
  input  logic               reset,

  // request side
  input  div_fn_t            req_fn,
  input  logic [width-1:0]   req_a,
  input  logic [width-1:0]   req_b,
  input  logic               req_val,
  output logic               req_rdy,

  // response side, remainder over quotient
  output logic [2*width-1:0] resp_result,
  output logic               resp_val,
  input  logic               resp_rdy
);

  // ----------------------------------------
  // operand stage to core
  // ----------------------------------------
  logic             op_val;
  logic             op_rdy;
  logic [width-1:0] op_mag_a;
  logic [width-1:0] op_mag_b;
  logic             op_neg_quot;
  logic             op_neg_rem;

  // ----------------------------------------
  // core to sign-fix stage
  // ----------------------------------------
  logic             core_val;
  logic             core_rdy;
  logic [width-1:0] core_quot;
  logic [width-1:0] core_rem;
  logic             core_neg_quot;
  logic             core_neg_rem;

  div_operand_stage #(.width(width)) operand_stage_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .op_val      (op_val),
    .op_mag_a    (op_mag_a),
    .op_mag_b    (op_mag_b),
    .op_neg_quot (op_neg_quot),
    .op_neg_rem  (op_neg_rem),
    .op_rdy      (op_rdy)
  );

  div_iterative_core #(.width(width)) iterative_core_i (
    .clk           (clk),
    .reset         (reset),
    .op_val        (op_val),
    .op_mag_a      (op_mag_a),
    .op_mag_b      (op_mag_b),
    .op_neg_quot   (op_neg_quot),
    .op_neg_rem    (op_neg_rem),
    .op_rdy        (op_rdy),
    .core_val      (core_val),
    .core_quot     (core_quot),
    .core_rem      (core_rem),
    .core_neg_quot (core_neg_quot),
    .core_neg_rem  (core_neg_rem),
    .core_rdy      (core_rdy)
  );

  div_sign_fix_stage #(.width(width)) sign_fix_stage_i (
    .clk           (clk),
    .reset         (reset),
    .core_val      (core_val),
    .core_quot     (core_quot),
    .core_rem      (core_rem),
    .core_neg_quot (core_neg_quot),
    .core_neg_rem  (core_neg_rem),
    .core_rdy      (core_rdy),
    .resp_result   (resp_result),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy)
  );

endmodule

`default_nettype wire

// ==== sim/int_div_unit_tb.sv ====
/* testbench for the integer divider unit, random and directed divisions are
   checked in order against a reference model, with and without back-pressure */
`default_nettype none

module int_div_unit_tb
  import div_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // 300 random, 13 directed, 200 under back-pressure, 4 in the fill test
  localparam int num_requests    = 517;
  localparam int watchdog_cycles = num_requests * 40 * 4 + 8;

  logic        clk;
  logic        reset;
  div_fn_t     req_fn;
  logic [31:0] req_a;
  logic [31:0] req_b;
  logic        req_val;
  logic        req_rdy;
  logic [63:0] resp_result;
  logic        resp_val;
  logic        resp_rdy;

  // results still owed by the DUT, oldest first
  logic [63:0] expected_q[$];
  logic [31:0] prod_rng;
  logic [31:0] cons_rng;
  int          error_count;
  int          check_count;
  int          tests_run;
  int          tests_failed;

  int_div_unit int_div_unit_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------
  // random numbers and reference model
  // ----------------------------------------

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // remainder over quotient, as the DUT packs it
  function automatic logic [63:0] model_div(input div_fn_t fn, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [31:0] quot;
    logic [31:0] rem;
    if (b == 32'd0) begin
      // all-ones magnitude, negated for a negative signed dividend
      rem  = a;
      quot = (fn == FN_DIV_SIGNED && a[31]) ? 32'd1 : 32'hffff_ffff;
    end else if (fn == FN_DIV_SIGNED && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      // overflow wraps
      quot = 32'h8000_0000;
      rem  = 32'd0;
    end else if (fn == FN_DIV_SIGNED) begin
      quot = $signed(a) / $signed(b);
      rem  = $signed(a) % $signed(b);
    end else begin
      quot = a / b;
      rem  = a % b;
    end
    return {rem, quot};
  endfunction

  // ----------------------------------------
  // checks and reporting
  // ----------------------------------------

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  // ----------------------------------------
  // producer side
  // ----------------------------------------

  // wide spread of divisor sizes, roughly one in sixteen is zero
  task automatic random_operands(output div_fn_t fn, output logic [31:0] a,
                                 output logic [31:0] b);
    logic [31:0] sel;
    prod_rng = lcg_step(prod_rng);
    a = prod_rng;
    prod_rng = lcg_step(prod_rng);
    b = prod_rng;
    prod_rng = lcg_step(prod_rng);
    sel = prod_rng;
    b = b >> sel[20:16];
    if (sel[27:24] == 4'd0) begin
      b = 32'd0;
    end
    fn = div_fn_t'(sel[31]);
  endtask

  // called on a rising edge, returns on the edge of the transfer
  task automatic send_request(input div_fn_t fn, input logic [31:0] a, input logic [31:0] b);
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    req_val <= 1'b1;
    @(posedge clk);
    while (!req_rdy) begin
      @(posedge clk);
    end
    expected_q.push_back(model_div(fn, a, b));
  endtask

  task automatic send_random(input int n);
    div_fn_t     fn;
    logic [31:0] a;
    logic [31:0] b;
    repeat (n) begin
      random_operands(fn, a, b);
      send_request(fn, a, b);
    end
    req_val <= 1'b0;
  endtask

  task automatic send_directed();
    send_request(FN_DIV_SIGNED, 32'd100, 32'd0);
    send_request(FN_DIV_SIGNED, 32'hffff_ff9c, 32'd0);
    send_request(FN_DIV_UNSIGNED, 32'hdead_beef, 32'd0);
    send_request(FN_DIV_SIGNED, 32'd0, 32'd0);
    send_request(FN_DIV_SIGNED, 32'd0, 32'd7);
    send_request(FN_DIV_UNSIGNED, 32'd0, 32'hffff_ffff);
    send_request(FN_DIV_SIGNED, 32'h8000_0000, 32'hffff_ffff);
    send_request(FN_DIV_UNSIGNED, 32'h8000_0000, 32'hffff_ffff);
    // equal magnitudes
    send_request(FN_DIV_SIGNED, 32'd12345, 32'hffff_cfc7);
    send_request(FN_DIV_UNSIGNED, 32'hffff_ffff, 32'hffff_ffff);
    send_request(FN_DIV_SIGNED, 32'h8000_0000, 32'h8000_0000);
    // negative remainders
    send_request(FN_DIV_SIGNED, 32'hffff_fff9, 32'd2);
    send_request(FN_DIV_SIGNED, 32'hffff_ff9c, 32'hffff_fff9);
    req_val <= 1'b0;
  endtask

  // ----------------------------------------
  // consumer side
  // ----------------------------------------

  task automatic drive_ready(input logic back_pressure);
    if (back_pressure) begin
      cons_rng = lcg_step(cons_rng);
      resp_rdy <= cons_rng[30];
    end else begin
      resp_rdy <= 1'b1;
    end
  endtask

  task automatic collect_responses(input int n, input logic back_pressure);
    int          got;
    logic        held;
    logic [63:0] held_val;
    logic [63:0] exp;
    got      = 0;
    held     = 1'b0;
    held_val = '0;
    drive_ready(back_pressure);
    while (got < n) begin
      @(posedge clk);
      // a stalled response must stay put
      if (held && !resp_val) begin
        error_count++;
        $display("response was withdrawn before resp_rdy took it");
      end else if (held) begin
        check_value("resp_result", held_val, resp_result);
      end
      if (resp_val && resp_rdy) begin
        if (expected_q.size() == 0) begin
          error_count++;
          $display("response arrived with no request outstanding");
        end else begin
          exp = expected_q.pop_front();
          check_value("resp_result", exp, resp_result);
        end
        got++;
      end
      held     = resp_val && !resp_rdy;
      held_val = resp_result;
      drive_ready(back_pressure);
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial begin
    int errors_before;
    int accepted;
    reset        = 1'b1;
    req_fn       = FN_DIV_SIGNED;
    req_a        = 32'd0;
    req_b        = 32'd0;
    req_val      = 1'b0;
    resp_rdy     = 1'b0;
    prod_rng     = 32'h566e_ebd5;
    cons_rng     = ~32'h566e_ebd5;
    error_count  = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    errors_before = error_count;
    repeat (10) begin
      @(posedge clk);
      check_value("req_rdy", 64'd1, 64'(req_rdy));
      check_value("resp_val", 64'd0, 64'(resp_val));
    end
    finish_test("reset state", errors_before);

    errors_before = error_count;
    fork
      send_random(300);
      collect_responses(300, 1'b0);
    join
    finish_test("random divisions", errors_before);

    errors_before = error_count;
    fork
      send_directed();
      collect_responses(13, 1'b0);
    join
    finish_test("corner cases", errors_before);

    errors_before = error_count;
    fork
      send_random(200);
      collect_responses(200, 1'b1);
    join
    finish_test("random back-pressure", errors_before);

    // one item per stage, the fourth waits for the release
    errors_before = error_count;
    resp_rdy <= 1'b0;
    fork
      send_random(4);
      begin
        accepted = 0;
        repeat (160) begin
          @(posedge clk);
          if (req_val && req_rdy) begin
            accepted++;
          end
        end
        check_value("accepted count", 64'd3, 64'(accepted));
        check_value("req_rdy", 64'd0, 64'(req_rdy));
        collect_responses(4, 1'b0);
      end
    join
    finish_test("pipeline fill", errors_before);

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/div_pkg.sv
hw/div_operand_stage.sv
hw/div_iterative_core.sv
hw/div_sign_fix_stage.sv
hw/int_div_unit.sv
sim/int_div_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the divider testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module int_div_unit_tb \
  -f vlog.f -o int_div_unit_sim \
  && ./obj_dir/int_div_unit_sim | tee sim.log \
  || { echo "build or run failed"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
